//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_sd_card
FILELIST  ?= files.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- files.f
+incdir+.
sd_emu_pkg.sv
spi_slave_phy.sv
sd_cmd_decoder.sv
sd_data_engine.sv
sd_sector_buffer.sv
sd_card.sv
sd_card_assertions.sv
tb_sd_card.sv

//--- sd_card.sv
// ------------------------------
// spi sd card emulation, top level
// io controller side serves sectors and config
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module sd_card import sd_emu_pkg::*; (
	input  logic     buffer_dout_strobe,
	input  logic     io_ack,
	// io controller link
	output sd_lba_t  io_lba,
	output logic     io_rd,
	output logic     io_wr,
	input  logic     io_done,
	output logic     io_conf,
	output logic     io_sdhc,
	input  sd_byte_t io_din,
	input  logic     io_din_strobe,
	output sd_byte_t io_dout,
	input  logic     io_dout_strobe,
	input  logic     allow_sdhc,
	// spi pins
	input  logic     sd_cs,
	input  logic     sd_sck,
	input  logic     sd_sdi,
	output logic     sd_sdo
);

	sd_byte_t    rx_byte;
	logic        rx_valid;
	sd_byte_t    tx_byte;
	logic        eng_busy;
	sd_byte_t    eng_tx_byte;
	blk_req_t    blk_req;
	logic        blk_valid;
	sector_ptr_t spi_addr;
	logic        spi_we;
	sd_byte_t    spi_wdata;
	sd_byte_t    spi_rdata;
	sector_ptr_t io_addr;
	logic        io_we;
	sd_byte_t    io_wdata;

	spi_slave_phy u_phy (
		.buffer_dout_strobe, .io_ack,
		.sd_cs, .sd_sck, .sd_sdi, .sd_sdo,
		.tx_byte, .rx_byte, .rx_valid
	);

	sd_cmd_decoder u_decoder (
		.buffer_dout_strobe, .io_ack,
		.rx_byte, .rx_valid, .io_sdhc,
		.eng_busy, .eng_tx_byte,
		.tx_byte, .blk_req, .blk_valid
	);

	sd_data_engine u_engine (
		.buffer_dout_strobe, .io_ack,
		.rx_byte, .rx_valid, .blk_req, .blk_valid,
		.io_done, .io_din, .io_din_strobe, .io_dout_strobe, .allow_sdhc,
		.eng_busy, .eng_tx_byte,
		.io_rd, .io_wr, .io_lba, .io_conf, .io_sdhc,
		.spi_addr, .spi_we, .spi_wdata,
		.io_addr, .io_we, .io_wdata,
		.spi_rdata
	);

	// io_dout follows the io side pointer
	sd_sector_buffer u_buffer (
		.buffer_dout_strobe,
		.spi_addr, .spi_we, .spi_wdata, .spi_rdata,
		.io_addr, .io_we, .io_wdata,
		.io_rdata (io_dout)
	);

endmodule

`default_nettype wire

//--- sd_card_assertions.sv
// ------------------------------
// io controller interface rules
// bound to sd_card from the testbench build
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module sd_card_assertions import sd_emu_pkg::*; (
	input logic    buffer_dout_strobe,
	input logic    io_ack,
	input logic    io_rd,
	input logic    io_wr,
	input logic    io_done,
	input sd_lba_t io_lba
);

	// one request direction at a time
	rd_wr_exclusive: assert property (@(posedge buffer_dout_strobe) disable iff (io_ack)
		!(io_rd && io_wr))
		else $error("io_rd and io_wr high together");

	// address held for the whole request
	lba_stable: assert property (@(posedge buffer_dout_strobe) disable iff (io_ack)
		((io_rd || io_wr) && $past(io_rd || io_wr)) |-> $stable(io_lba))
		else $error("io_lba moved during a request");

	// read request drops on the clock after io_done
	rd_release: assert property (@(posedge buffer_dout_strobe) disable iff (io_ack)
		(io_rd && io_done) |=> !io_rd)
		else $error("io_rd still high after io_done");

endmodule

bind sd_card sd_card_assertions u_assertions (
	.buffer_dout_strobe (buffer_dout_strobe),
	.io_ack             (io_ack),
	.io_rd              (io_rd),
	.io_wr              (io_wr),
	.io_done            (io_done),
	.io_lba             (io_lba)
);

`default_nettype wire

//--- sd_cmd_decoder.sv
// ------------------------------
// sd command frame decoder and r1 reply sequencer
// passes block commands on and muxes the engine's bytes out
// ------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "sd_emu_defines.svh"

module sd_cmd_decoder import sd_emu_pkg::*; (
	input  logic     buffer_dout_strobe,
	input  logic     io_ack,
	input  sd_byte_t rx_byte,
	input  logic     rx_valid,
	input  logic     io_sdhc,
	input  logic     eng_busy,
	input  sd_byte_t eng_tx_byte,
	output sd_byte_t tx_byte,
	output blk_req_t blk_req,
	output logic     blk_valid
);

	cmd_frame_t frame;
	// 0 waits for a command byte, 1..5 count argument and crc bytes
	logic [2:0] frame_cnt;
	logic       frame_valid;
	logic       cmd55;
	sd_byte_t   r1;
	sd_byte_t   r1_c;
	// extra reply bytes, all 0xff when there are none
	sd_lba_t    extra;
	sd_lba_t    extra_c;
	blk_req_t   req_c;
	// reply byte slot after the frame, 0 when no reply is running
	sd_byte_t   slot;
	sd_byte_t   tx_reg;

	assign frame_valid = rx_valid && (frame_cnt == 3'd5);
	// after r1 of a block command the engine owns the line
	assign tx_byte = eng_busy ? eng_tx_byte : tx_reg;

	// r1 table, evaluated while the crc byte completes
	always_comb begin
		r1_c = 8'h04;
		extra_c = '1;
		req_c = '0;
		case (frame.cmd_index)
			`SD_CMD_GO_IDLE: r1_c = 8'h01;
			`SD_CMD_SEND_OP_COND: r1_c = 8'h00;
			`SD_CMD_SEND_IF_COND: begin
				r1_c = 8'h01;
				// voltage accepted, check pattern echoed
				extra_c = 32'h0000_01AA;
			end
			`SD_CMD_SEND_CSD, `SD_CMD_SEND_CID: begin
				r1_c = 8'h00;
				req_c.rd = 1'b1;
				req_c.wr = 1'b1;
				req_c.arg = {31'd0, frame.cmd_index == `SD_CMD_SEND_CSD};
			end
			// only 512 byte blocks
			`SD_CMD_SET_BLOCKLEN:
				r1_c = (frame.arg == {22'd0, `SD_SECTOR_BYTES}) ? 8'h00 : 8'h40;
			`SD_CMD_READ_BLOCK: begin
				r1_c = 8'h00;
				req_c.rd = 1'b1;
				req_c.arg = frame.arg;
			end
			`SD_CMD_WRITE_BLOCK: begin
				r1_c = 8'h00;
				req_c.wr = 1'b1;
				req_c.arg = frame.arg;
			end
			`SD_CMD_APP_OP_COND: r1_c = cmd55 ? 8'h00 : 8'h04;
			`SD_CMD_APP_CMD: r1_c = 8'h01;
			`SD_CMD_READ_OCR: begin
				r1_c = 8'h00;
				// bit 30 flags a high capacity card
				extra_c = {1'b0, io_sdhc, 30'd0};
			end
			default: ;
		endcase
	end

	always_ff @(posedge buffer_dout_strobe or posedge io_ack) begin
		if (io_ack) begin
			frame_cnt <= '0;
			cmd55 <= 1'b0;
			slot <= '0;
			tx_reg <= 8'hFF;
			blk_valid <= 1'b0;
		end else begin
			blk_valid <= 1'b0;
			if (rx_valid) begin
				// command bytes start with 01, none taken during a transfer
				if (frame_cnt == 3'd0) begin
					if (rx_byte[7:6] == 2'b01 && !eng_busy)
						frame_cnt <= 3'd1;
				end else begin
					frame_cnt <= (frame_cnt == 3'd5) ? 3'd0 : frame_cnt + 3'd1;
				end
				if (frame_valid) begin
					cmd55 <= (frame.cmd_index == `SD_CMD_APP_CMD);
					slot <= 8'd1;
					tx_reg <= 8'hFF;
				end else if (slot != 8'd0) begin
					slot <= (slot == `SD_NCR + 8'd5) ? 8'd0 : slot + 8'd1;
					// r1 goes out in the slot after the gap
					if (slot == `SD_NCR) begin
						tx_reg <= r1;
						blk_valid <= blk_req.rd | blk_req.wr;
					end else if (slot > `SD_NCR) begin
						tx_reg <= extra[31:24];
					end
				end
			end
		end
	end

	// frame and reply payload
	always_ff @(posedge buffer_dout_strobe) begin
		if (rx_valid) begin
			if (frame_cnt == 3'd0)
				frame.cmd_index <= rx_byte[5:0];
			else if (frame_cnt != 3'd5)
				frame.arg <= {frame.arg[23:0], rx_byte};
			if (frame_valid) begin
				r1 <= r1_c;
				extra <= extra_c;
				blk_req <= req_c;
			end else if (slot > `SD_NCR) begin
				extra <= {extra[23:0], 8'hFF};
			end
		end
	end

endmodule

`default_nettype wire

//--- sd_data_engine.sv
// ------------------------------
// block read and write engine with the io controller requests
// also holds the cid, csd and config bytes loaded at start-up
// ------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "sd_emu_defines.svh"

module sd_data_engine import sd_emu_pkg::*; (
	input  logic        buffer_dout_strobe,
	input  logic        io_ack,
	input  sd_byte_t    rx_byte,
	input  logic        rx_valid,
	input  blk_req_t    blk_req,
	input  logic        blk_valid,
	input  logic        io_done,
	input  sd_byte_t    io_din,
	input  logic        io_din_strobe,
	input  logic        io_dout_strobe,
	input  logic        allow_sdhc,
	output logic        eng_busy,
	output sd_byte_t    eng_tx_byte,
	output logic        io_rd,
	output logic        io_wr,
	output sd_lba_t     io_lba,
	output logic        io_conf,
	output logic        io_sdhc,
	output sector_ptr_t spi_addr,
	output logic        spi_we,
	output sd_byte_t    spi_wdata,
	output sector_ptr_t io_addr,
	output logic        io_we,
	output sd_byte_t    io_wdata,
	input  sd_byte_t    spi_rdata
);

	rd_state_e   rd_state;
	wr_state_e   wr_state;
	sector_ptr_t spi_ptr;
	sector_ptr_t io_ptr;
	sd_lba_t     lba;
	logic        id_rd;
	logic        id_csd;
	// counts the two crc bytes
	logic        crc_cnt;
	conf_ptr_t   conf_ptr;
	sd_byte_t    conf_byte;
	sd_byte_t    id_mem [2 * `SD_ID_BYTES];
	logic        conf_we;
	logic        sector_last;
	logic        rd_last;

	assign eng_busy = (rd_state != RD_IDLE) || (wr_state != WR_IDLE);
	// bit 0 of the config byte says the real card is sdhc
	assign io_sdhc = allow_sdhc & conf_byte[0];
	// byte addressed cards get the sector number
	assign io_lba = io_sdhc ? lba : {9'd0, lba[31:9]};
	assign io_conf = (conf_ptr != `SD_CONF_BYTES);
	// strobes with no request pending carry config bytes
	assign conf_we = io_din_strobe && !io_rd && !io_wr && io_conf;
	assign sector_last = ({1'b0, spi_ptr} == `SD_SECTOR_BYTES - 10'd1);
	assign rd_last = id_rd ? (spi_ptr == {3'd0, `SD_ID_BYTES - 6'd1}) : sector_last;
	assign spi_addr = spi_ptr;
	assign spi_we = rx_valid && (wr_state == WR_RECV_DATA);
	assign spi_wdata = rx_byte;
	assign io_addr = io_ptr;
	assign io_we = io_rd && io_din_strobe;
	assign io_wdata = io_din;

	always_ff @(posedge buffer_dout_strobe) begin
		if (conf_we && conf_ptr < `SD_CONF_BYTES - 6'd1)
			id_mem[conf_ptr[4:0]] <= io_din;
	end

	always_ff @(posedge buffer_dout_strobe or posedge io_ack) begin
		if (io_ack) begin
			rd_state <= RD_IDLE;
			wr_state <= WR_IDLE;
			io_rd <= 1'b0;
			io_wr <= 1'b0;
			spi_ptr <= '0;
			io_ptr <= '0;
			lba <= '0;
			id_rd <= 1'b0;
			id_csd <= 1'b0;
			crc_cnt <= 1'b0;
			conf_ptr <= '0;
			conf_byte <= '0;
			eng_tx_byte <= 8'hFF;
		end else begin
			if (conf_we) begin
				conf_ptr <= conf_ptr + 6'd1;
				if (conf_ptr == `SD_CONF_BYTES - 6'd1)
					conf_byte <= io_din;
			end
			// io side walks the buffer one byte per strobe
			if (blk_valid)
				io_ptr <= '0;
			else if (io_we || (io_wr && io_dout_strobe))
				io_ptr <= io_ptr + 9'd1;
			if (blk_valid) begin
				lba <= blk_req.arg;
				id_rd <= blk_req.rd & blk_req.wr;
				id_csd <= blk_req.arg[0];
				eng_tx_byte <= 8'hFF;
				if (blk_req.rd) begin
					rd_state <= blk_req.wr ? RD_SEND_TOKEN : RD_WAIT_IO;
					io_rd <= !blk_req.wr;
				end else begin
					wr_state <= WR_EXP_TOKEN;
				end
			end

			// each byte queued here goes out in the following slot
			case (rd_state)
				RD_WAIT_IO:
					if (io_done) begin
						io_rd <= 1'b0;
						rd_state <= RD_SEND_TOKEN;
					end
				RD_SEND_TOKEN:
					if (rx_valid) begin
						eng_tx_byte <= `SD_TOKEN_DATA;
						spi_ptr <= '0;
						rd_state <= RD_SEND_DATA;
					end
				RD_SEND_DATA:
					if (rx_valid) begin
						eng_tx_byte <= id_rd ? id_mem[{id_csd, spi_ptr[3:0]}] : spi_rdata;
						spi_ptr <= spi_ptr + 9'd1;
						if (rd_last) begin
							crc_cnt <= 1'b0;
							rd_state <= RD_SEND_CRC;
						end
					end
				// crc is not generated, two 0xff bytes stand in
				RD_SEND_CRC:
					if (rx_valid) begin
						eng_tx_byte <= 8'hFF;
						crc_cnt <= 1'b1;
						if (crc_cnt)
							rd_state <= RD_IDLE;
					end
				default: ;
			endcase

			case (wr_state)
				WR_EXP_TOKEN:
					if (rx_valid && rx_byte == `SD_TOKEN_DATA) begin
						spi_ptr <= '0;
						wr_state <= WR_RECV_DATA;
					end
				WR_RECV_DATA:
					if (rx_valid) begin
						spi_ptr <= spi_ptr + 9'd1;
						if (sector_last) begin
							crc_cnt <= 1'b0;
							wr_state <= WR_RECV_CRC;
						end
					end
				// received crc bytes are ignored
				WR_RECV_CRC:
					if (rx_valid) begin
						crc_cnt <= 1'b1;
						if (crc_cnt) begin
							eng_tx_byte <= `SD_RESP_DATA_OK;
							wr_state <= WR_SEND_RESP;
						end
					end
				// sector is complete, hand it to the io controller
				WR_SEND_RESP:
					if (rx_valid) begin
						eng_tx_byte <= 8'h00;
						io_wr <= 1'b1;
						wr_state <= WR_BUSY;
					end
				WR_BUSY:
					if (io_done) begin
						io_wr <= 1'b0;
						wr_state <= WR_IDLE;
					end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- sd_emu_defines.svh
// ------------------------------
// constants of the sd card emulation
// include where timing, sizes or command codes are needed
// ------------------------------
`ifndef SD_EMU_DEFINES_SVH
`define SD_EMU_DEFINES_SVH

// 0xff bytes between the last command byte and r1
`define SD_NCR          8'd4
`define SD_SECTOR_BYTES 10'd512
// cid and csd are the same length
`define SD_ID_BYTES     6'd16
// cid, then csd, then one config byte
`define SD_CONF_BYTES   6'd33
`define SD_TOKEN_DATA   8'hFE
`define SD_RESP_DATA_OK 8'h05

// command indexes
`define SD_CMD_GO_IDLE      6'd0
`define SD_CMD_SEND_OP_COND 6'd1
`define SD_CMD_SEND_IF_COND 6'd8
`define SD_CMD_SEND_CSD     6'd9
`define SD_CMD_SEND_CID     6'd10
`define SD_CMD_SET_BLOCKLEN 6'd16
`define SD_CMD_READ_BLOCK   6'd17
`define SD_CMD_WRITE_BLOCK  6'd24
`define SD_CMD_APP_OP_COND  6'd41
`define SD_CMD_APP_CMD      6'd55
`define SD_CMD_READ_OCR     6'd58

`endif

//--- sd_emu_pkg.sv
// ------------------------------
// types shared by the sd card emulation blocks
// import with a wildcard in the module header
// ------------------------------
`default_nettype none

package sd_emu_pkg;

	typedef logic [7:0]  sd_byte_t;
	// command argument, also a byte or block address
	typedef logic [31:0] sd_lba_t;
	typedef logic [8:0]  sector_ptr_t;
	// index into cid, csd and config byte
	typedef logic [5:0]  conf_ptr_t;

	// one decoded command frame
	typedef struct packed {
		logic [5:0] cmd_index;
		sd_lba_t    arg;
	} cmd_frame_t;

	// block command from decoder to engine
	// rd and wr together mark a cid/csd read, arg[0] then picks the csd
	typedef struct packed {
		logic    rd;
		logic    wr;
		sd_lba_t arg;
	} blk_req_t;

	typedef enum logic [2:0] {
		RD_IDLE,
		RD_WAIT_IO,
		RD_SEND_TOKEN,
		RD_SEND_DATA,
		RD_SEND_CRC
	} rd_state_e;

	typedef enum logic [2:0] {
		WR_IDLE,
		WR_EXP_TOKEN,
		WR_RECV_DATA,
		WR_RECV_CRC,
		WR_SEND_RESP,
		WR_BUSY
	} wr_state_e;

endpackage

`default_nettype wire

//--- sd_sector_buffer.sv
// ------------------------------
// one sector of storage, spi port and io port
// both ports have registered reads
// ------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "sd_emu_defines.svh"

module sd_sector_buffer import sd_emu_pkg::*; (
	input  logic        buffer_dout_strobe,
	// spi side
	input  sector_ptr_t spi_addr,
	input  logic        spi_we,
	input  sd_byte_t    spi_wdata,
	output sd_byte_t    spi_rdata,
	// io controller side
	input  sector_ptr_t io_addr,
	input  logic        io_we,
	input  sd_byte_t    io_wdata,
	output sd_byte_t    io_rdata
);

	sd_byte_t mem [`SD_SECTOR_BYTES];

	// the two sides never write in the same transfer
	always_ff @(posedge buffer_dout_strobe) begin
		if (spi_we)
			mem[spi_addr] <= spi_wdata;
		if (io_we)
			mem[io_addr] <= io_wdata;
		spi_rdata <= mem[spi_addr];
		io_rdata <= mem[io_addr];
	end

endmodule

`default_nettype wire

//--- spi_slave_phy.sv
// ------------------------------
// spi slave pin logic, oversampled on the system clock
// gives received bytes and sends the byte queued by its owner
// ------------------------------
`timescale 1ns/1ps
`default_nettype none

module spi_slave_phy import sd_emu_pkg::*; (
	input  logic     buffer_dout_strobe,
	input  logic     io_ack,
	input  logic     sd_cs,
	input  logic     sd_sck,
	input  logic     sd_sdi,
	input  sd_byte_t tx_byte,
	output logic     sd_sdo,
	output sd_byte_t rx_byte,
	output logic     rx_valid
);

	// two sync flops, the third sck stage finds edges
	logic [2:0] sck_sync;
	logic [1:0] cs_sync;
	logic [1:0] sdi_sync;
	logic       sck_rise;
	logic       sck_fall;
	logic       cs_n;
	logic       sdi_s;
	// set by the first 0 bit after cs falls
	logic       synced;
	logic [2:0] bit_cnt;
	logic       bit_in;
	logic       byte_done;
	logic [6:0] rx_sr;
	logic [6:0] tx_sr;
	// byte for the next byte slot
	sd_byte_t   tx_next;
	logic       load_d;

	assign sck_rise = sck_sync[1] & ~sck_sync[2];
	assign sck_fall = ~sck_sync[1] & sck_sync[2];
	assign cs_n = cs_sync[1];
	assign sdi_s = sdi_sync[1];
	assign bit_in = !cs_n && sck_rise && (synced || !sdi_s);
	assign byte_done = bit_in && (bit_cnt == 3'd7);

	always_ff @(posedge buffer_dout_strobe or posedge io_ack) begin
		if (io_ack) begin
			sck_sync <= '0;
			cs_sync <= '1;
			sdi_sync <= '1;
			synced <= 1'b0;
			bit_cnt <= '0;
			rx_valid <= 1'b0;
			load_d <= 1'b0;
			tx_next <= 8'hFF;
			tx_sr <= '1;
			sd_sdo <= 1'b1;
		end else begin
			sck_sync <= {sck_sync[1:0], sd_sck};
			cs_sync <= {cs_sync[0], sd_cs};
			sdi_sync <= {sdi_sync[0], sd_sdi};
			rx_valid <= byte_done;
			// owner answers rx_valid one clock later, take it on the next
			load_d <= rx_valid;
			if (load_d)
				tx_next <= tx_byte;
			if (cs_n) begin
				synced <= 1'b0;
				bit_cnt <= '0;
				sd_sdo <= 1'b1;
			end else begin
				if (bit_in) begin
					synced <= 1'b1;
					bit_cnt <= bit_cnt + 3'd1;
				end
				// sdo moves after falling sck, msb first
				if (sck_fall) begin
					if (bit_cnt == 3'd0) begin
						sd_sdo <= tx_next[7];
						tx_sr <= {tx_next[6:0]};
					end else begin
						sd_sdo <= tx_sr[6];
						tx_sr <= {tx_sr[5:0], 1'b1};
					end
				end
			end
		end
	end

	// receive shifter, sampled on rising sck
	always_ff @(posedge buffer_dout_strobe) begin
		if (bit_in)
			rx_sr <= {rx_sr[5:0], sdi_s};
		if (byte_done)
			rx_byte <= {rx_sr, sdi_s};
	end

endmodule

`default_nettype wire

//--- tb_sd_card.sv
// ------------------------------
// testbench for the sd card emulation
// spi host tasks, io controller model, reply reference
// ------------------------------
`timescale 1ns/1ps
`default_nettype none
`include "sd_emu_defines.svh"

module tb_sd_card import sd_emu_pkg::*; ();

	logic     buffer_dout_strobe;
	logic     io_ack;
	logic     io_done;
	logic     io_din_strobe;
	logic     io_dout_strobe;
	logic     allow_sdhc;
	logic     sd_cs;
	logic     sd_sck;
	logic     sd_sdi;
	sd_byte_t io_din;
	sd_lba_t  io_lba;
	logic     io_rd;
	logic     io_wr;
	logic     io_conf;
	logic     io_sdhc;
	logic     sd_sdo;
	sd_byte_t io_dout;

	integer   seed;
	integer   errors;
	integer   checks;
	integer   err_mark;
	logic     cmd55_flag;
	sd_byte_t conf [33];
	// bytes expected on the spi or io side for the current block
	sd_byte_t exp_data [512];
	sd_byte_t b;

	sd_card u_dut (.*);

	initial buffer_dout_strobe = 1'b0;
	always #10 buffer_dout_strobe = ~buffer_dout_strobe;

	// stop a run that hangs
	initial begin
		#10_000_000;
		$display("simulation timed out, no end of test reached");
		$display("Something failed");
		$finish;
	end

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (exp === act) else begin
			$display("** Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic report_fail(input string what);
		$display("error at %0t ns: %s", $time, what);
		errors++;
	endtask

	task automatic end_test(input string name);
		$display("test %s: %s", name, (errors == err_mark) ? "passed" : "FAILED");
		err_mark = errors;
	endtask

	// expected r1 and four extra bytes with 0xff where a command has none
	function automatic logic [39:0] expect_reply(input logic [5:0] idx, input sd_lba_t arg,
		input logic after55, input logic sdhc);
		case (idx)
			6'd0, 6'd55: return {8'h01, 32'hFFFF_FFFF};
			6'd1, 6'd9, 6'd10, 6'd17, 6'd24: return {8'h00, 32'hFFFF_FFFF};
			6'd8: return {8'h01, 32'h0000_01AA};
			6'd16: return {(arg == 32'd512) ? 8'h00 : 8'h40, 32'hFFFF_FFFF};
			6'd41: return {after55 ? 8'h00 : 8'h04, 32'hFFFF_FFFF};
			6'd58: return {8'h00, 1'b0, sdhc, 30'd0};
			default: return {8'h04, 32'hFFFF_FFFF};
		endcase
	endfunction

	// block number when the card is byte addressed
	function automatic sd_lba_t lba_for(input sd_lba_t arg, input logic sdhc);
		return sdhc ? arg : (arg >> 9);
	endfunction

	// one spi mode 0 byte at 8 clocks per bit and msb first
	task automatic spi_xfer(input sd_byte_t tx, output sd_byte_t rx);
		for (int i = 7; i >= 0; i--) begin
			@(posedge buffer_dout_strobe);
			sd_sdi <= tx[i];
			repeat (2) @(posedge buffer_dout_strobe);
			@(negedge buffer_dout_strobe);
			rx[i] = sd_sdo;
			@(posedge buffer_dout_strobe);
			sd_sck <= 1'b1;
			repeat (4) @(posedge buffer_dout_strobe);
			sd_sck <= 1'b0;
		end
	endtask

	// sends a frame and compares gap, r1 and extra bytes with the reference
	task automatic run_cmd(input logic [5:0] idx, input sd_lba_t arg, input int n_extra);
		logic [39:0] reply;
		logic [39:0] exp;
		logic        sdhc;
		sd_byte_t    rx;
		reply = '1;
		spi_xfer({2'b01, idx}, rx);
		for (int i = 3; i >= 0; i--)
			spi_xfer(arg[8 * i +: 8], rx);
		// crc is not checked by the card
		spi_xfer(8'hFF, rx);
		// sdhc as the io controller set it up for this command
		@(negedge buffer_dout_strobe);
		sdhc = allow_sdhc & conf[32][0];
		exp = expect_reply(idx, arg, cmd55_flag, sdhc);
		check_value("io_sdhc", sdhc, io_sdhc);
		for (int i = 0; i < 4; i++) begin
			spi_xfer(8'hFF, rx);
			check_value("ncr gap byte", 8'hFF, rx);
		end
		spi_xfer(8'hFF, rx);
		reply[39:32] = rx;
		for (int i = 0; i < n_extra; i++) begin
			spi_xfer(8'hFF, rx);
			reply[31 - 8 * i -: 8] = rx;
		end
		check_value("r1", exp[39:32], reply[39:32]);
		if (n_extra > 0)
			check_value("extra reply bytes", exp[31:0], reply[31:0]);
		cmd55_flag = (idx == 6'd55);
	endtask

	// waits for the data token and reads n bytes and two crc bytes
	task automatic read_data(input int n, input string name);
		sd_byte_t rx;
		int       polls;
		rx = 8'hFF;
		polls = 0;
		while (rx != `SD_TOKEN_DATA && polls < 400) begin
			spi_xfer(8'hFF, rx);
			polls++;
		end
		if (rx != `SD_TOKEN_DATA) begin
			report_fail("no data token from the card");
		end else begin
			for (int i = 0; i < n; i++) begin
				spi_xfer(8'hFF, rx);
				check_value(name, exp_data[i], rx);
			end
			repeat (2) begin
				spi_xfer(8'hFF, rx);
				check_value("crc byte", 8'hFF, rx);
			end
		end
	endtask

	// io controller answers a read with random sector bytes
	task automatic serve_read(input sd_lba_t exp_lba);
		int t;
		t = 0;
		while (!io_rd && t < 5000) begin
			@(negedge buffer_dout_strobe);
			t++;
		end
		if (!io_rd) begin
			report_fail("io_rd did not rise");
		end else begin
			check_value("io_lba", exp_lba, io_lba);
			for (int i = 0; i < 512; i++) begin
				exp_data[i] = $random(seed);
				@(posedge buffer_dout_strobe);
				io_din <= exp_data[i];
				io_din_strobe <= 1'b1;
				@(posedge buffer_dout_strobe);
				io_din_strobe <= 1'b0;
			end
			@(posedge buffer_dout_strobe);
			io_done <= 1'b1;
			@(posedge buffer_dout_strobe);
			io_done <= 1'b0;
			@(negedge buffer_dout_strobe);
			check_value("io_rd", 1'b0, io_rd);
		end
	endtask

	// host side of a write with token, data, crc and the data response
	task automatic write_host();
		sd_byte_t rx;
		int       t;
		spi_xfer(`SD_TOKEN_DATA, rx);
		for (int i = 0; i < 512; i++) begin
			exp_data[i] = $random(seed);
			spi_xfer(exp_data[i], rx);
		end
		repeat (2) spi_xfer(8'hFF, rx);
		spi_xfer(8'hFF, rx);
		check_value("data response", `SD_RESP_DATA_OK, rx);
		// busy bytes are 0x00 until the io controller is done
		rx = 8'h00;
		t = 0;
		while (rx == 8'h00 && t < 400) begin
			spi_xfer(8'hFF, rx);
			t++;
		end
		if (rx == 8'h00)
			report_fail("card stayed busy after the write");
		else
			check_value("byte after busy", 8'hFF, rx);
	endtask

	// io controller takes the sector one strobe per byte
	task automatic serve_write(input sd_lba_t exp_lba);
		int t;
		t = 0;
		while (!io_wr && t < 60000) begin
			@(negedge buffer_dout_strobe);
			t++;
		end
		if (!io_wr) begin
			report_fail("io_wr did not rise");
		end else begin
			check_value("io_lba", exp_lba, io_lba);
			for (int i = 0; i < 512; i++) begin
				@(negedge buffer_dout_strobe);
				check_value("io_dout", exp_data[i], io_dout);
				@(posedge buffer_dout_strobe);
				io_dout_strobe <= 1'b1;
				@(posedge buffer_dout_strobe);
				io_dout_strobe <= 1'b0;
				// registered read needs one more clock
				@(posedge buffer_dout_strobe);
			end
			@(posedge buffer_dout_strobe);
			io_done <= 1'b1;
			@(posedge buffer_dout_strobe);
			io_done <= 1'b0;
			@(negedge buffer_dout_strobe);
			check_value("io_wr", 1'b0, io_wr);
		end
	endtask

	// loads cid and csd and the config byte with sdhc allowed
	task automatic load_config();
		for (int i = 0; i < 33; i++) begin
			conf[i] = (i == 32) ? 8'h01 : $random(seed);
			@(posedge buffer_dout_strobe);
			io_din <= conf[i];
			io_din_strobe <= 1'b1;
			@(posedge buffer_dout_strobe);
			io_din_strobe <= 1'b0;
		end
		@(negedge buffer_dout_strobe);
		check_value("io_conf", 1'b0, io_conf);
	endtask

	initial begin
		seed = 46326;
		errors = 0;
		checks = 0;
		err_mark = 0;
		cmd55_flag = 1'b0;
		io_ack = 1'b1;
		io_done = 1'b0;
		io_din = '0;
		io_din_strobe = 1'b0;
		io_dout_strobe = 1'b0;
		allow_sdhc = 1'b1;
		sd_cs = 1'b1;
		sd_sck = 1'b0;
		sd_sdi = 1'b1;
		repeat (8) @(posedge buffer_dout_strobe);
		io_ack <= 1'b0;
		repeat (4) @(posedge buffer_dout_strobe);

		@(negedge buffer_dout_strobe);
		check_value("io_rd", 1'b0, io_rd);
		check_value("io_wr", 1'b0, io_wr);
		check_value("io_conf", 1'b1, io_conf);
		// cs high keeps sdo at 1
		spi_xfer(8'h00, b);
		check_value("sd_sdo", 8'hFF, b);
		end_test("reset state");

		load_config();
		@(posedge buffer_dout_strobe);
		sd_cs <= 1'b0;
		repeat (4) @(posedge buffer_dout_strobe);
		run_cmd(6'd0, 32'd0, 0);
		run_cmd(6'd8, 32'h0000_01AA, 4);
		run_cmd(6'd55, 32'd0, 0);
		run_cmd(6'd41, 32'h4000_0000, 0);
		run_cmd(6'd16, 32'd512, 0);
		run_cmd(6'd16, 32'd1024, 0);
		run_cmd(6'd13, 32'd0, 0);
		@(posedge buffer_dout_strobe);
		allow_sdhc <= 1'b0;
		run_cmd(6'd58, 32'd0, 4);
		@(posedge buffer_dout_strobe);
		allow_sdhc <= 1'b1;
		run_cmd(6'd58, 32'd0, 4);
		end_test("config and replies");

		for (int i = 0; i < 16; i++)
			exp_data[i] = conf[16 + i];
		run_cmd(6'd9, 32'd0, 0);
		read_data(16, "csd byte");
		for (int i = 0; i < 16; i++)
			exp_data[i] = conf[i];
		run_cmd(6'd10, 32'd0, 0);
		read_data(16, "cid byte");
		end_test("cid and csd");

		run_cmd(6'd17, 32'h0000_1234, 0);
		fork
			read_data(512, "read data byte");
			serve_read(lba_for(32'h0000_1234, 1'b1));
		join
		end_test("single block read");

		@(posedge buffer_dout_strobe);
		allow_sdhc <= 1'b0;
		run_cmd(6'd24, 32'h0004_0000, 0);
		fork
			write_host();
			serve_write(lba_for(32'h0004_0000, 1'b0));
		join
		end_test("single block write");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire
